/* logic/tlb_l2_params.svh */
`ifndef TLB_L2_PARAMS_SVH
`define TLB_L2_PARAMS_SVH

// Address widths
`define TLB_IN_AW      32  // Slave side
`define TLB_OUT_AW     40  // Master side
`define TLB_CFG_AW     32
`define TLB_CFG_DW     64

// Geometry
`define TLB_SETS       32
`define TLB_OFFSETS    4   // Entries per half of a set
`define TLB_BANKS      4   // Searched in parallel
`define TLB_PAGE_BITS  12  // 4 KiB pages

// VA entry flags below the page number
`define TLB_VA_VALID_BIT 0
`define TLB_VA_RO_BIT    1

// Config address bit that selects the PA RAM
`define TLB_CFG_PA_SEL   10

`endif

/* logic/tlb_l2_pkg.sv */
`default_nettype none

`include "tlb_l2_params.svh"

package tlb_l2_pkg;

   // Search control FSM
   typedef enum logic [1:0] {
      IDLE,
      SEARCH,
      DONE
   } search_state_e;

   // Result FSM
   typedef enum logic [1:0] {
      OUT_IDLE,
      SEND_OUTPUT,
      OUT_SENT
   } out_state_e;

   typedef logic [$clog2(`TLB_SETS)-1:0]                       set_idx_t;
   typedef logic [$clog2(`TLB_OFFSETS)-1:0]                    offset_t;
   typedef logic [$clog2(`TLB_SETS)+$clog2(`TLB_OFFSETS):0]    va_addr_t;  // {set, half, offset}
   typedef logic [$clog2(`TLB_BANKS)-1:0]                      bank_idx_t;
   typedef logic [$bits(va_addr_t)+$clog2(`TLB_BANKS)-1:0]     pa_addr_t;  // {entry, bank}
   typedef logic [`TLB_IN_AW-`TLB_PAGE_BITS-1:0]               vpn_t;
   typedef logic [`TLB_OUT_AW-`TLB_PAGE_BITS-1:0]              ppn_t;

endpackage

`default_nettype wire

/* logic/tlb_l2_search_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_params.svh"

module tlb_l2_search_ctrl (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  l1_miss_i,
   input  logic [`TLB_IN_AW-1:0] in_addr_i,
   input  logic                  rw_write_i,
   input  logic                  stop_i,
   input  logic                  result_i,
   input  logic                  trans_sent_i,
   output logic [`TLB_IN_AW-1:0] addr_o,
   output logic                  rw_write_o,
   output tlb_l2_pkg::set_idx_t  set_o,
   output tlb_l2_pkg::offset_t   offset_o,
   output logic                  searching_o,
   output logic                  cmp_valid_o,
   output logic                  search_done_o,
   output logic                  busy_o
);

   localparam tlb_l2_pkg::offset_t LAST_OFFSET = tlb_l2_pkg::offset_t'(`TLB_OFFSETS - 1);

   tlb_l2_pkg::search_state_e state_q, state_d;
   logic [`TLB_IN_AW-1:0]     addr_q;
   logic                      rw_write_q;
   logic                      accept;
   tlb_l2_pkg::offset_t       offset_q;
   logic                      last_rd_q;    // Last offset is being compared
   logic                      cmp_valid_q;
   logic                      busy_q, busy_d;

   assign accept = (state_q == tlb_l2_pkg::IDLE) && l1_miss_i;

   ////////////////////////////////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////////////////////////////////
   always_comb begin
      state_d       = state_q;
      busy_d        = busy_q;
      search_done_o = 1'b0;
      unique case (state_q)
         tlb_l2_pkg::IDLE: begin
            if (l1_miss_i) begin
               state_d = tlb_l2_pkg::SEARCH;
               busy_d  = 1'b1;
            end
         end
         tlb_l2_pkg::SEARCH: begin
            // Ends on the first hit or fault or after the last compare
            if (stop_i || last_rd_q) begin
               state_d       = tlb_l2_pkg::DONE;
               search_done_o = 1'b1;
            end
         end
         tlb_l2_pkg::DONE: begin
            if (trans_sent_i || result_i) begin
               state_d = tlb_l2_pkg::IDLE;
               busy_d  = 1'b0;
            end
         end
         default: state_d = tlb_l2_pkg::IDLE;
      endcase
   end

   // Reads stop once the last offset is out
   assign searching_o = (state_q == tlb_l2_pkg::SEARCH) && !last_rd_q;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q     <= tlb_l2_pkg::IDLE;
         busy_q      <= 1'b0;
         offset_q    <= '0;
         last_rd_q   <= 1'b0;
         cmp_valid_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         busy_q      <= busy_d;
         last_rd_q   <= searching_o && (offset_q == LAST_OFFSET);
         cmp_valid_q <= searching_o && !stop_i;  // RAM read takes one cycle
         if (accept) begin
            offset_q <= '0;
         end else if (searching_o && (offset_q != LAST_OFFSET)) begin
            offset_q <= offset_q + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Address and access type
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q     <= in_addr_i;
         rw_write_q <= rw_write_i;
      end
   end

   assign addr_o      = accept ? in_addr_i : addr_q;  // Live in the accept cycle
   assign rw_write_o  = accept ? rw_write_i : rw_write_q;
   assign set_o       = addr_o[`TLB_PAGE_BITS +: $bits(tlb_l2_pkg::set_idx_t)];
   assign offset_o    = offset_q;
   assign cmp_valid_o = cmp_valid_q;
   assign busy_o      = busy_q;

endmodule

`default_nettype wire

/* logic/tlb_l2_va_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_params.svh"

module tlb_l2_va_bank #(
   parameter int unsigned BANK_IDX = 0
) (
   input  logic                    clk_i,
   input  logic [`TLB_BANKS-1:0]   we_i,       // One enable per bank
   input  tlb_l2_pkg::va_addr_t    waddr_i,
   input  logic [`TLB_IN_AW-1:0]   wdata_i,
   input  tlb_l2_pkg::set_idx_t    set_i,
   input  tlb_l2_pkg::offset_t     offset_i,
   input  logic                    rd_en_i,
   input  logic                    cmp_valid_i,
   input  tlb_l2_pkg::vpn_t        vpn_i,
   input  logic                    rw_write_i,
   output logic                    hit_o,
   output logic                    prot_o,
   output logic                    multi_o,
   output tlb_l2_pkg::va_addr_t    hit_addr_o
);

   localparam int unsigned DEPTH   = 1 << $bits(tlb_l2_pkg::va_addr_t);
   localparam int unsigned ENTRY_W = $bits(tlb_l2_pkg::vpn_t) + 2;  // {vpn, ro, valid}
   localparam int unsigned HALF    = $bits(tlb_l2_pkg::offset_t);

   logic [ENTRY_W-1:0]    mem [DEPTH];
   logic [ENTRY_W-1:0]    wentry;
   logic                  we;
   tlb_l2_pkg::va_addr_t  port_addr [2];
   logic [ENTRY_W-1:0]    rdata_q [2];
   tlb_l2_pkg::va_addr_t  raddr_q;
   logic [1:0]            word_hit, word_prot;

   assign we     = we_i[BANK_IDX];
   assign wentry = {wdata_i[`TLB_IN_AW-1:`TLB_PAGE_BITS],
                    wdata_i[`TLB_VA_RO_BIT],
                    wdata_i[`TLB_VA_VALID_BIT]};

   // Port 0 lower half and writes, port 1 upper half
   assign port_addr[0] = we ? waddr_i : {set_i, 1'b0, offset_i};
   assign port_addr[1] = {set_i, 1'b1, offset_i};

   ////////////////////////////////////////////////////////////////////
   // Dual-port RAM
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (we) begin
         mem[port_addr[0]] <= wentry;
      end
      if (rd_en_i) begin
         rdata_q[0] <= mem[port_addr[0]];
         rdata_q[1] <= mem[port_addr[1]];
         raddr_q    <= port_addr[0];
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Tag compare
   ////////////////////////////////////////////////////////////////////
   always_comb begin
      logic match;
      for (int p = 0; p < 2; p++) begin
         match = rdata_q[p][0] && (rdata_q[p][ENTRY_W-1:2] == vpn_i);
         word_hit[p]  = match && !(rw_write_i && rdata_q[p][1]);
         word_prot[p] = match && rw_write_i && rdata_q[p][1];  // Write to read-only page
      end
   end

   assign hit_o   = cmp_valid_i && (|word_hit);
   assign prot_o  = cmp_valid_i && (|word_prot);
   assign multi_o = cmp_valid_i && (&word_hit);

   // Lower half wins when both match
   always_comb begin
      hit_addr_o       = raddr_q;
      hit_addr_o[HALF] = !word_hit[0];
   end

endmodule

`default_nettype wire

/* logic/tlb_l2_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_params.svh"

module tlb_l2_result (
   input  logic                                     clk_i,
   input  logic                                     rst_ni,
   input  logic [`TLB_BANKS-1:0]                    bank_hit_i,
   input  logic [`TLB_BANKS-1:0]                    bank_prot_i,
   input  logic [`TLB_BANKS-1:0]                    bank_multi_i,
   input  tlb_l2_pkg::va_addr_t [`TLB_BANKS-1:0]    bank_hit_addr_i,
   input  logic                                     search_done_i,
   input  logic                                     l1_miss_i,
   output logic                                     stop_o,
   output tlb_l2_pkg::pa_addr_t                     pa_raddr_o,
   output logic                                     hit_o,
   output logic                                     miss_o,
   output logic                                     prot_o,
   output logic                                     multi_hit_o
);

   tlb_l2_pkg::out_state_e  out_q, out_d;
   logic                    any_hit, any_prot;
   logic                    first_hit, multi;
   tlb_l2_pkg::bank_idx_t   hit_bank;
   logic                    hit_d, miss_d, prot_d, multi_d;

   assign any_hit  = |bank_hit_i;
   assign any_prot = |bank_prot_i;
   assign stop_o   = any_hit || any_prot;

   // A second hit in bank order makes it a multi hit
   always_comb begin
      first_hit = 1'b0;
      multi     = 1'b0;
      hit_bank  = '0;
      for (int i = 0; i < `TLB_BANKS; i++) begin
         if (bank_hit_i[i]) begin
            if (first_hit || bank_multi_i[i]) begin
               multi = 1'b1;
            end
            if (!first_hit) begin
               first_hit = 1'b1;
               hit_bank  = tlb_l2_pkg::bank_idx_t'(i);
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Output FSM
   ////////////////////////////////////////////////////////////////////
   always_comb begin
      out_d      = out_q;
      hit_d      = 1'b0;
      miss_d     = 1'b0;
      prot_d     = 1'b0;
      multi_d    = 1'b0;
      pa_raddr_o = '0;
      unique case (out_q)
         tlb_l2_pkg::OUT_IDLE: begin
            if (search_done_i) begin
               out_d   = tlb_l2_pkg::SEND_OUTPUT;
               multi_d = multi;
               prot_d  = any_prot;
               if (!multi && !any_prot) begin
                  hit_d  = first_hit;
                  miss_d = !first_hit;
               end
               // PA index is entry times bank count plus bank
               pa_raddr_o = {bank_hit_addr_i[hit_bank], hit_bank};
            end
         end
         tlb_l2_pkg::SEND_OUTPUT: out_d = tlb_l2_pkg::OUT_SENT;
         tlb_l2_pkg::OUT_SENT: begin
            if (l1_miss_i) begin
               out_d = tlb_l2_pkg::OUT_IDLE;
            end
         end
         default: out_d = tlb_l2_pkg::OUT_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         out_q       <= tlb_l2_pkg::OUT_IDLE;
         hit_o       <= 1'b0;
         miss_o      <= 1'b0;
         prot_o      <= 1'b0;
         multi_hit_o <= 1'b0;
      end else begin
         out_q       <= out_d;
         hit_o       <= hit_d;   // Lines up with the PA RAM read
         miss_o      <= miss_d;
         prot_o      <= prot_d;
         multi_hit_o <= multi_d;
      end
   end

endmodule

`default_nettype wire

/* logic/tlb_l2_pa_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_params.svh"

module tlb_l2_pa_lookup (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic                     we_i,
   input  tlb_l2_pkg::pa_addr_t     waddr_i,
   input  logic [`TLB_OUT_AW-1:0]   wdata_i,
   input  tlb_l2_pkg::pa_addr_t     raddr_i,
   input  logic [`TLB_PAGE_BITS-1:0] page_off_i,
   input  logic                     hit_i,
   output logic [`TLB_OUT_AW-1:0]   out_addr_o
);

   localparam int unsigned DEPTH = 1 << $bits(tlb_l2_pkg::pa_addr_t);

   tlb_l2_pkg::ppn_t      mem [DEPTH];
   tlb_l2_pkg::pa_addr_t  addr;
   tlb_l2_pkg::ppn_t      rdata_q;
   tlb_l2_pkg::ppn_t      ppn_q;
   tlb_l2_pkg::ppn_t      ppn;

   assign addr = we_i ? waddr_i : raddr_i;  // Writes take the port

   ////////////////////////////////////////////////////////////////////
   // Single-port RAM
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[addr] <= wdata_i[`TLB_OUT_AW-1:`TLB_PAGE_BITS];
      end
      rdata_q <= mem[addr];
   end

   // Hold the page number until the next hit
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         ppn_q <= '0;
      end else if (hit_i) begin
         ppn_q <= rdata_q;
      end
   end

   assign ppn        = hit_i ? rdata_q : ppn_q;
   assign out_addr_o = {ppn, page_off_i};

endmodule

`default_nettype wire

/* logic/tlb_l2.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_params.svh"

module tlb_l2 (
   input  logic                   clk_i,
   input  logic                   rst_ni,
   input  logic [`TLB_IN_AW-1:0]  in_addr_i,
   input  logic                   rw_write_i,  // 1 for write
   input  logic                   l1_miss_i,
   input  logic                   cfg_we_i,
   input  logic [`TLB_CFG_AW-1:0] cfg_addr_i,
   input  logic [`TLB_CFG_DW-1:0] cfg_wdata_i,
   input  logic                   trans_sent_i,
   output logic                   hit_o,
   output logic                   miss_o,
   output logic                   prot_o,
   output logic                   multi_hit_o,
   output logic                   busy_o,
   output logic [`TLB_OUT_AW-1:0] out_addr_o
);

   localparam int unsigned BANK_W = $bits(tlb_l2_pkg::bank_idx_t);
   localparam int unsigned VA_W   = $bits(tlb_l2_pkg::va_addr_t);

   // Configuration decode
   logic                                   va_we, pa_we;
   logic [`TLB_BANKS-1:0]                  bank_we;
   tlb_l2_pkg::bank_idx_t                  cfg_bank;
   tlb_l2_pkg::va_addr_t                   va_waddr;
   tlb_l2_pkg::pa_addr_t                   pa_waddr;

   // Search
   logic [`TLB_IN_AW-1:0]                  addr;
   logic                                   rw_write;
   tlb_l2_pkg::set_idx_t                   set;
   tlb_l2_pkg::offset_t                    offset;
   logic                                   searching, cmp_valid, search_done;
   logic                                   stop, result_nohit;
   logic [`TLB_BANKS-1:0]                  bank_hit, bank_prot, bank_multi;
   tlb_l2_pkg::va_addr_t [`TLB_BANKS-1:0]  bank_hit_addr;
   tlb_l2_pkg::pa_addr_t                   pa_raddr;

   ////////////////////////////////////////////////////////////////////
   // Configuration write decode
   ////////////////////////////////////////////////////////////////////
   assign va_we    = cfg_we_i && !cfg_addr_i[`TLB_CFG_PA_SEL];
   assign pa_we    = cfg_we_i && cfg_addr_i[`TLB_CFG_PA_SEL];
   assign cfg_bank = cfg_addr_i[BANK_W-1:0];
   assign va_waddr = cfg_addr_i[VA_W+BANK_W-1:BANK_W];
   assign pa_waddr = cfg_addr_i[$bits(tlb_l2_pkg::pa_addr_t)-1:0];

   always_comb begin
      for (int b = 0; b < `TLB_BANKS; b++) begin
         bank_we[b] = va_we && (cfg_bank == tlb_l2_pkg::bank_idx_t'(b));
      end
   end

   assign result_nohit = miss_o || prot_o || multi_hit_o;

   tlb_l2_search_ctrl i_search_ctrl (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .l1_miss_i     (l1_miss_i),
      .in_addr_i     (in_addr_i),
      .rw_write_i    (rw_write_i),
      .stop_i        (stop),
      .result_i      (result_nohit),
      .trans_sent_i  (trans_sent_i),
      .addr_o        (addr),
      .rw_write_o    (rw_write),
      .set_o         (set),
      .offset_o      (offset),
      .searching_o   (searching),
      .cmp_valid_o   (cmp_valid),
      .search_done_o (search_done),
      .busy_o        (busy_o)
   );

   for (genvar b = 0; b < `TLB_BANKS; b++) begin : g_bank
      tlb_l2_va_bank #(
         .BANK_IDX (b)
      ) i_va_bank (
         .clk_i       (clk_i),
         .we_i        (bank_we),
         .waddr_i     (va_waddr),
         .wdata_i     (cfg_wdata_i[`TLB_IN_AW-1:0]),
         .set_i       (set),
         .offset_i    (offset),
         .rd_en_i     (searching),
         .cmp_valid_i (cmp_valid),
         .vpn_i       (addr[`TLB_IN_AW-1:`TLB_PAGE_BITS]),
         .rw_write_i  (rw_write),
         .hit_o       (bank_hit[b]),
         .prot_o      (bank_prot[b]),
         .multi_o     (bank_multi[b]),
         .hit_addr_o  (bank_hit_addr[b])
      );
   end

   tlb_l2_result i_result (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .bank_hit_i      (bank_hit),
      .bank_prot_i     (bank_prot),
      .bank_multi_i    (bank_multi),
      .bank_hit_addr_i (bank_hit_addr),
      .search_done_i   (search_done),
      .l1_miss_i       (l1_miss_i),
      .stop_o          (stop),
      .pa_raddr_o      (pa_raddr),
      .hit_o           (hit_o),
      .miss_o          (miss_o),
      .prot_o          (prot_o),
      .multi_hit_o     (multi_hit_o)
   );

   tlb_l2_pa_lookup i_pa_lookup (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .we_i       (pa_we),
      .waddr_i    (pa_waddr),
      .wdata_i    (cfg_wdata_i[`TLB_OUT_AW-1:0]),
      .raddr_i    (pa_raddr),
      .page_off_i (addr[`TLB_PAGE_BITS-1:0]),
      .hit_i      (hit_o),
      .out_addr_o (out_addr_o)
   );

endmodule

`default_nettype wire

/* test/tb_tlb_l2.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_params.svh"

module tb_tlb_l2;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 4;
   localparam int NUM_TESTS    = 6;
   localparam int FILL_WRITES  = `TLB_SETS * 2 * `TLB_OFFSETS * `TLB_BANKS;
   localparam int WATCHDOG_CYCLES =
      NUM_TESTS * (`TLB_OFFSETS + 20) + RESET_CYCLES + FILL_WRITES;

   logic                   clk_i, rst_ni;
   logic [`TLB_IN_AW-1:0]  in_addr_i;
   logic                   rw_write_i, l1_miss_i, cfg_we_i, trans_sent_i;
   logic [`TLB_CFG_AW-1:0] cfg_addr_i;
   logic [`TLB_CFG_DW-1:0] cfg_wdata_i;
   logic                   hit_o, miss_o, prot_o, multi_hit_o, busy_o;
   logic [`TLB_OUT_AW-1:0] out_addr_o;

   // Result of the last search
   logic                   res_hit, res_miss, res_prot, res_multi, res_seen;
   logic [`TLB_OUT_AW-1:0] res_addr;

   string cur_test;
   int    test_errs, errors, checks, tests_run, tests_failed;

   tlb_l2 i_dut (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .in_addr_i    (in_addr_i),
      .rw_write_i   (rw_write_i),
      .l1_miss_i    (l1_miss_i),
      .cfg_we_i     (cfg_we_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_wdata_i  (cfg_wdata_i),
      .trans_sent_i (trans_sent_i),
      .hit_o        (hit_o),
      .miss_o       (miss_o),
      .prot_o       (prot_o),
      .multi_hit_o  (multi_hit_o),
      .busy_o       (busy_o),
      .out_addr_o   (out_addr_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Checks and reporting
   //////////////////////////////////////////////////////////////////////
   task automatic report_failure(input string msg);
      $display("error in %s: %s", cur_test, msg);
      errors++;
      test_errs++;
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         $display("mismatch %s %s: expected %0b actual %0b", cur_test, what, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic check_addr(input string what, input logic [`TLB_OUT_AW-1:0] exp,
                             input logic [`TLB_OUT_AW-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("test %s ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", cur_test, test_errs);
      end
   endtask

   task automatic check_outputs_idle();
      check_bit("hit_o", 1'b0, hit_o);
      check_bit("miss_o", 1'b0, miss_o);
      check_bit("prot_o", 1'b0, prot_o);
      check_bit("multi_hit_o", 1'b0, multi_hit_o);
      check_bit("busy_o", 1'b0, busy_o);
   endtask

   task automatic check_result(input logic hit, input logic miss, input logic prot,
                               input logic multi);
      if (!res_seen) return;
      check_bit("hit_o", hit, res_hit);
      check_bit("miss_o", miss, res_miss);
      check_bit("prot_o", prot, res_prot);
      check_bit("multi_hit_o", multi, res_multi);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks start and end 2 ns after a rising edge
   //////////////////////////////////////////////////////////////////////
   function automatic tlb_l2_pkg::va_addr_t entry_addr(input tlb_l2_pkg::set_idx_t set,
                                                       input logic half,
                                                       input tlb_l2_pkg::offset_t off);
      return {set, half, off};
   endfunction

   function automatic tlb_l2_pkg::vpn_t pick_vpn(input tlb_l2_pkg::set_idx_t set);
      tlb_l2_pkg::vpn_t vpn;
      vpn = tlb_l2_pkg::vpn_t'($urandom());
      vpn[$bits(tlb_l2_pkg::set_idx_t)-1:0] = set;  // Low page bits pick the set
      return vpn;
   endfunction

   function automatic tlb_l2_pkg::ppn_t pick_ppn();
      return tlb_l2_pkg::ppn_t'({$urandom(), $urandom()});
   endfunction

   task automatic write_cfg(input logic [`TLB_CFG_AW-1:0] addr,
                            input logic [`TLB_CFG_DW-1:0] data);
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      @(posedge clk_i);
      #2;
      cfg_we_i = 1'b0;
   endtask

   task automatic write_va(input tlb_l2_pkg::bank_idx_t bank, input tlb_l2_pkg::va_addr_t entry,
                           input tlb_l2_pkg::vpn_t vpn, input logic ro);
      write_cfg(`TLB_CFG_AW'({entry, bank}),
                `TLB_CFG_DW'({vpn, {(`TLB_PAGE_BITS-2){1'b0}}, ro, 1'b1}));
   endtask

   task automatic write_pa(input tlb_l2_pkg::bank_idx_t bank, input tlb_l2_pkg::va_addr_t entry,
                           input tlb_l2_pkg::ppn_t ppn);
      write_cfg(`TLB_CFG_AW'({1'b1, entry, bank}), `TLB_CFG_DW'({ppn, `TLB_PAGE_BITS'(0)}));
   endtask

   // Every VA entry starts out invalid
   task automatic clear_va_banks();
      for (int e = 0; e < (1 << $bits(tlb_l2_pkg::va_addr_t)); e++) begin
         for (int b = 0; b < `TLB_BANKS; b++) begin
            write_cfg(`TLB_CFG_AW'({tlb_l2_pkg::va_addr_t'(e), tlb_l2_pkg::bank_idx_t'(b)}), '0);
         end
      end
   endtask

   task automatic run_search(input logic [`TLB_IN_AW-1:0] addr, input logic write);
      int cycles;
      res_seen   = 1'b0;
      in_addr_i  = addr;
      rw_write_i = write;
      l1_miss_i  = 1'b1;
      @(posedge clk_i);
      #2;
      l1_miss_i = 1'b0;
      @(negedge clk_i);
      check_bit("busy_o after l1 miss", 1'b1, busy_o);
      cycles = 1;
      while (!(hit_o | miss_o | prot_o | multi_hit_o) && cycles < `TLB_OFFSETS + 5) begin
         @(negedge clk_i);
         cycles++;
      end
      if (hit_o | miss_o | prot_o | multi_hit_o) begin
         res_seen  = 1'b1;
         res_hit   = hit_o;
         res_miss  = miss_o;
         res_prot  = prot_o;
         res_multi = multi_hit_o;
         res_addr  = out_addr_o;
         @(negedge clk_i);  // Pulses last one cycle
         check_bit("hit_o width", 1'b0, hit_o);
         check_bit("miss_o width", 1'b0, miss_o);
         check_bit("prot_o width", 1'b0, prot_o);
         check_bit("multi_hit_o width", 1'b0, multi_hit_o);
      end else begin
         report_failure($sformatf("no result pulse within %0d cycles of the l1 miss", cycles));
      end
      @(posedge clk_i);
      #2;
   endtask

   // Busy holds until the cycle after trans_sent
   task automatic release_hit(input logic [`TLB_OUT_AW-1:0] exp_addr);
      @(negedge clk_i);
      check_bit("busy_o held", 1'b1, busy_o);
      @(posedge clk_i);
      #2;
      trans_sent_i = 1'b1;
      @(negedge clk_i);
      check_bit("busy_o at trans_sent", 1'b1, busy_o);
      @(posedge clk_i);
      #2;
      trans_sent_i = 1'b0;
      @(negedge clk_i);
      check_bit("busy_o after trans_sent", 1'b0, busy_o);
      check_addr("out_addr_o held", exp_addr, out_addr_o);
      @(posedge clk_i);
      #2;
   endtask

   task automatic wait_release();
      @(negedge clk_i);
      check_bit("busy_o two cycles after the result", 1'b0, busy_o);
      @(posedge clk_i);
      #2;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////
   task automatic test_reset();
      begin_test("reset");
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk_i);
         #2;
         check_outputs_idle();
      end
      rst_ni = 1'b1;
      repeat (2) begin
         @(negedge clk_i);
         check_outputs_idle();
      end
      @(posedge clk_i);
      #2;
      end_test();
   endtask

   task automatic test_hit();
      tlb_l2_pkg::vpn_t     vpn;
      tlb_l2_pkg::ppn_t     ppn;
      tlb_l2_pkg::va_addr_t entry;
      begin_test("hit");
      vpn   = pick_vpn(5);
      ppn   = pick_ppn();
      entry = entry_addr(5, 1'b0, 1);
      write_va(2, entry, vpn, 1'b0);
      write_pa(2, entry, ppn);
      run_search({vpn, 12'h5a3}, 1'b0);
      check_result(1'b1, 1'b0, 1'b0, 1'b0);
      check_addr("out_addr_o", {ppn, 12'h5a3}, res_addr);
      release_hit({ppn, 12'h5a3});
      end_test();
   endtask

   task automatic test_miss();
      tlb_l2_pkg::vpn_t vpn;
      begin_test("miss");
      vpn = pick_vpn(20);  // Nothing stored in this set
      run_search({vpn, 12'h010}, 1'b0);
      check_result(1'b0, 1'b1, 1'b0, 1'b0);
      wait_release();
      vpn = pick_vpn(9);
      write_va(1, entry_addr(9, 1'b0, `TLB_OFFSETS - 1), vpn, 1'b0);
      run_search({vpn ^ 20'h80000, 12'h010}, 1'b0);  // Same set, other page
      check_result(1'b0, 1'b1, 1'b0, 1'b0);
      wait_release();
      end_test();
   endtask

   task automatic test_prot();
      tlb_l2_pkg::vpn_t     vpn;
      tlb_l2_pkg::ppn_t     ppn;
      tlb_l2_pkg::va_addr_t entry;
      begin_test("prot");
      vpn   = pick_vpn(12);
      ppn   = pick_ppn();
      entry = entry_addr(12, 1'b0, 2);
      write_va(0, entry, vpn, 1'b1);  // Read-only page
      write_pa(0, entry, ppn);
      run_search({vpn, 12'hffc}, 1'b1);
      check_result(1'b0, 1'b0, 1'b1, 1'b0);
      wait_release();
      run_search({vpn, 12'hffc}, 1'b0);
      check_result(1'b1, 1'b0, 1'b0, 1'b0);
      check_addr("out_addr_o", {ppn, 12'hffc}, res_addr);
      release_hit({ppn, 12'hffc});
      end_test();
   endtask

   task automatic test_multi();
      tlb_l2_pkg::vpn_t     vpn;
      tlb_l2_pkg::va_addr_t entry;
      begin_test("multi");
      vpn   = pick_vpn(17);
      entry = entry_addr(17, 1'b0, 1);
      write_va(0, entry, vpn, 1'b0);
      write_va(3, entry, vpn, 1'b0);
      run_search({vpn, 12'h044}, 1'b0);
      check_result(1'b0, 1'b0, 1'b0, 1'b1);
      wait_release();
      vpn = pick_vpn(23);  // Both halves of one bank
      write_va(2, entry_addr(23, 1'b0, 0), vpn, 1'b0);
      write_va(2, entry_addr(23, 1'b1, 0), vpn, 1'b0);
      run_search({vpn, 12'h044}, 1'b0);
      check_result(1'b0, 1'b0, 1'b0, 1'b1);
      wait_release();
      end_test();
   endtask

   task automatic test_upper();
      tlb_l2_pkg::vpn_t     vpn;
      tlb_l2_pkg::ppn_t     ppn;
      tlb_l2_pkg::va_addr_t entry;
      begin_test("upper");
      vpn   = pick_vpn(26);
      ppn   = pick_ppn();
      entry = entry_addr(26, 1'b1, `TLB_OFFSETS - 1);  // Upper half, last offset
      write_va(1, entry, vpn, 1'b0);
      write_pa(1, entry, ppn);
      run_search({vpn, 12'h7e8}, 1'b0);
      check_result(1'b1, 1'b0, 1'b0, 1'b0);
      check_addr("out_addr_o", {ppn, 12'h7e8}, res_addr);
      release_hit({ppn, 12'h7e8});
      end_test();
   endtask

   initial begin
      rst_ni       = 1'b0;
      in_addr_i    = '0;
      rw_write_i   = 1'b0;
      l1_miss_i    = 1'b0;
      cfg_we_i     = 1'b0;
      cfg_addr_i   = '0;
      cfg_wdata_i  = '0;
      trans_sent_i = 1'b0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(36));

      test_reset();
      clear_va_banks();
      test_hit();
      test_miss();
      test_prot();
      test_multi();
      test_upper();

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/tlb_l2_pkg.sv
logic/tlb_l2_search_ctrl.sv
logic/tlb_l2_va_bank.sv
logic/tlb_l2_result.sv
logic/tlb_l2_pa_lookup.sv
logic/tlb_l2.sv
test/tb_tlb_l2.sv

/* Bender.yml */
package:
  name: tlb_l2

sources:
  - include_dirs:
      - logic
    files:
      - logic/tlb_l2_pkg.sv
      - logic/tlb_l2_search_ctrl.sv
      - logic/tlb_l2_va_bank.sv
      - logic/tlb_l2_result.sv
      - logic/tlb_l2_pa_lookup.sv
      - logic/tlb_l2.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_tlb_l2.sv
